//--- files.f
+incdir+include
hw/lcd_video_pkg.sv
hw/lcd_capture.sv
hw/frame_store.sv
hw/raster_scan.sv
hw/pixel_shade.sv
hw/lcd_video_top.sv
tests/tb_lcd_video.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the LCD video testbench with Verilator, runs it and checks the result
cd "$(dirname "$0")" &&
verilator --binary --timing --timescale 1ns/1ps -f files.f \
    --top-module tb_lcd_video -o sim_lcd_video &&
./obj_dir/sim_lcd_video | tee /dev/stderr | grep -q "^Simulation finished: PASS$" &&
echo "run_sim: passed" ||
{
    echo "run_sim: failed"
    exit 1
}

//--- tests/tb_lcd_video.sv
// Testbench for the LCD video path top level.
// An LCD model serves random frames to the capture side; a reference model
// of the contrast table and palette predicts every displayed pixel.
// Run through files.f with the testbench as top module.

`include "lcd_consts.svh"

module tb_lcd_video;
    timeunit 1ns;
    timeprecision 1ps;

    import lcd_video_pkg::*;

    localparam int FRAME_CYCLES   = `H_TOTAL * `V_TOTAL;
    localparam int CAPTURE_CYCLES = 2 * `FB_DEPTH + 8;        // column_ce every other cycle
    localparam int TIMEOUT_CYCLES = 10 * FRAME_CYCLES + 4 * CAPTURE_CYCLES + 64;
    localparam int ACTIVE_PIXELS  = `LCD_XSIZE * `LCD_YSIZE;

    // {off, on} levels of contrast rows 00, 1F and 3F
    localparam int LEVEL_ROWS [3][2] = '{'{0, 4}, '{15, 255}, '{240, 255}};

    logic      clk_sys;
    logic      reset;
    logic      frame_complete;
    logic      column_ce;
    column_t   lcd_column;
    contrast_t lcd_contrast;
    logic      pix_ce;
    logic      blend_mode;
    lcd_x_t    lcd_read_x;
    lcd_row_t  lcd_read_y;
    channel_t  red;
    channel_t  green;
    channel_t  blue;
    logic      hsync;
    logic      vsync;
    logic      hblank;
    logic      vblank;

    // lcd model and the captured history ordered newest first
    column_t     lcd_mem [`FB_DEPTH];
    column_t     frame_hist [4][`FB_DEPTH];
    contrast_t   con_hist [4];
    logic [31:0] lfsr;
    int          check_req;
    logic        check_pixels;
    int          test_count;

    // owned by the compare process
    int   errors = 0;
    int   checks = 0;
    int   checks_done = 0;
    int   act_count = 0;
    int   hs_count = 0;
    int   pix_x = 0;
    int   pix_y = 0;
    logic in_check = 1'b0;
    logic reset_checked = 1'b0;
    logic hsync_q = 1'b0;
    logic vsync_q = 1'b0;
    int   cycles = 0;

    lcd_video_top dut0
    (
        .clk_sys        (clk_sys),
        .reset          (reset),
        .frame_complete (frame_complete),
        .column_ce      (column_ce),
        .lcd_column     (lcd_column),
        .lcd_contrast   (lcd_contrast),
        .pix_ce         (pix_ce),
        .blend_mode     (blend_mode),
        .lcd_read_x     (lcd_read_x),
        .lcd_read_y     (lcd_read_y),
        .red            (red),
        .green          (green),
        .blue           (blue),
        .hsync          (hsync),
        .vsync          (vsync),
        .hblank         (hblank),
        .vblank         (vblank)
    );

    always #10 clk_sys = ~clk_sys;

    //////////////////////////////////////////////////////////////////////
    // reference model

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic int table_level(input contrast_t con, input logic on_bit);
        int row;
        case (con)
            6'h00:   row = 0;
            6'h1F:   row = 1;
            default: row = 2;       // 3F
        endcase
        return LEVEL_ROWS[row][int'(on_bit)];
    endfunction

    // expected colour channel (0 red, 1 green, 2 blue) of image pixel x, y
    function automatic channel_t expected_channel(input int x, input int y, input int ch);
        int      lvl [4];
        int      lvl_sum;
        int      i;
        int      off_c;
        int      on_c;
        column_t col;
        lvl_sum = 0;
        for (int age = 0; age < 4; age++)
        begin
            col      = frame_hist[age][(y / 8) * `LCD_XSIZE + x];
            lvl[age] = table_level(con_hist[age], col[y % 8]);
            lvl_sum += lvl[age];
        end
        i = blend_mode ? lvl_sum / 4 : lvl[0];
        case (ch)
            0:
            begin
                off_c = int'(`OFF_R);
                on_c  = int'(`ON_R);
            end
            1:
            begin
                off_c = int'(`OFF_G);
                on_c  = int'(`ON_G);
            end
            default:
            begin
                off_c = int'(`OFF_B);
                on_c  = int'(`ON_B);
            end
        endcase
        return channel_t'(((255 - i) * off_c + i * on_c) / 255);
    endfunction

    task automatic check_channel(input string what, input channel_t got, input channel_t exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("FAIL %0t: %s, got %02h expected %02h", $time, what, got, exp);
        end
    endtask

    task automatic check_count(input string what, input int got, input int exp);
        checks++;
        if (got != exp)
        begin
            errors++;
            $display("FAIL %0t: %s, got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // compare process sampling on the falling edge

    always @(negedge clk_sys)
    begin
        if (!reset && !pix_ce && !reset_checked)
        begin
            check_count("hsync after reset", int'(hsync), 0);
            check_count("vsync after reset", int'(vsync), 0);
            check_count("hblank after reset", int'(hblank), 1);
            check_count("vblank after reset", int'(vblank), 1);
            check_channel("red after reset", red, 8'h00);
            check_channel("green after reset", green, 8'h00);
            check_channel("blue after reset", blue, 8'h00);
            reset_checked = 1'b1;
        end
        if (hsync && !hsync_q)
            hs_count++;
        if (!hblank && !vblank)
        begin
            if (in_check && check_pixels && act_count < ACTIVE_PIXELS)
            begin
                pix_x = act_count % `LCD_XSIZE;
                pix_y = act_count / `LCD_XSIZE;
                check_channel($sformatf("red at %0d,%0d", pix_x, pix_y), red,
                              expected_channel(pix_x, pix_y, 0));
                check_channel($sformatf("green at %0d,%0d", pix_x, pix_y), green,
                              expected_channel(pix_x, pix_y, 1));
                check_channel($sformatf("blue at %0d,%0d", pix_x, pix_y), blue,
                              expected_channel(pix_x, pix_y, 2));
            end
            act_count++;
        end
        else if (in_check)
        begin
            check_channel("red while blanked", red, 8'h00);     // black outside the image
            check_channel("green while blanked", green, 8'h00);
            check_channel("blue while blanked", blue, 8'h00);
        end
        if (vsync && !vsync_q)              // frame boundary
        begin
            if (in_check)
            begin
                check_count("hsync pulses per frame", hs_count, `V_TOTAL);
                check_count("active outputs per frame", act_count, ACTIVE_PIXELS);
                in_check = 1'b0;
                checks_done++;
            end
            else if (check_req != checks_done)
                in_check = 1'b1;
            hs_count  = 0;
            act_count = 0;
        end
        hsync_q = hsync;
        vsync_q = vsync;
    end

    always @(posedge clk_sys)
    begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES)
        begin
            $display("timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus

    task automatic next_cycle;
        @(negedge clk_sys);
        column_ce  = !column_ce;
        lcd_column = lcd_mem[int'(lcd_read_y) * `LCD_XSIZE + int'(lcd_read_x)];
    endtask

    // fills the lcd model with a random frame that the capture side reads out
    task automatic capture_frame(input contrast_t con);
        int      strobes;
        column_t col;
        for (int a = 0; a < `FB_DEPTH; a++)
        begin
            col = '0;
            for (int b = 0; b < 8; b++)
            begin
                lfsr   = lfsr_step(lfsr);
                col[b] = lfsr[0];
            end
            lcd_mem[a] = col;
        end
        lcd_contrast   = con;
        frame_complete = 1'b1;
        next_cycle();
        frame_complete = 1'b0;
        strobes        = 0;
        while (strobes < `FB_DEPTH)
        begin
            if (column_ce)
                strobes++;
            next_cycle();
        end
        for (int age = 3; age > 0; age--)
        begin
            frame_hist[age] = frame_hist[age - 1];
            con_hist[age]   = con_hist[age - 1];
        end
        frame_hist[0] = lcd_mem;
        con_hist[0]   = con;
    endtask

    // waits one whole raster frame from vsync to vsync
    task automatic check_frame(input logic with_pixels);
        check_pixels = with_pixels;
        check_req++;
        while (checks_done != check_req)
            next_cycle();
    endtask

    task automatic report_test(input string name, input int errors_before);
        test_count++;
        $display("test %0d %s: %s", test_count, name,
                 (errors == errors_before) ? "ok" : "mismatches");
    endtask

    initial
    begin
        int e0;
        clk_sys        = 1'b0;
        reset          = 1'b1;
        frame_complete = 1'b0;
        column_ce      = 1'b0;
        lcd_column     = '0;
        lcd_contrast   = '0;
        pix_ce         = 1'b0;
        blend_mode     = 1'b0;
        lfsr           = 32'hdb3e_ee18;
        check_req      = 0;
        check_pixels   = 1'b0;
        test_count     = 0;
        for (int a = 0; a < `FB_DEPTH; a++)
            lcd_mem[a] = '0;

        e0 = errors;
        repeat (8) next_cycle();
        reset = 1'b0;
        while (!reset_checked)
            next_cycle();
        report_test("reset values", e0);
        pix_ce = 1'b1;              // raster runs from here on

        e0 = errors;
        check_frame(1'b0);
        report_test("raster timing", e0);

        e0 = errors;
        capture_frame(6'h3F);
        check_frame(1'b1);
        report_test("capture and display", e0);

        e0 = errors;
        capture_frame(6'h00);
        check_frame(1'b1);
        capture_frame(6'h1F);
        check_frame(1'b1);
        report_test("contrast rows", e0);

        e0 = errors;
        capture_frame(6'h3F);
        blend_mode = 1'b1;          // four frames now stored
        check_frame(1'b1);
        report_test("four frame blend", e0);

        $display("%0d tests, %0d checks, %0d errors", test_count, checks, errors);
        if (errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

//--- hw/lcd_video_top.sv
// LCD video path top level.
// Capture feeds the four-bank frame store; the raster scan reads it back and
// the shading stage turns the banks into RGB with sync and blank flags.

module lcd_video_top
(
    input  logic                     clk_sys,
    input  logic                     reset,
    input  logic                     frame_complete,
    input  logic                     column_ce,
    input  lcd_video_pkg::column_t   lcd_column,
    input  lcd_video_pkg::contrast_t lcd_contrast,
    input  logic                     pix_ce,
    input  logic                     blend_mode,
    output lcd_video_pkg::lcd_x_t    lcd_read_x,
    output lcd_video_pkg::lcd_row_t  lcd_read_y,
    output lcd_video_pkg::channel_t  red,
    output lcd_video_pkg::channel_t  green,
    output lcd_video_pkg::channel_t  blue,
    output logic                     hsync,
    output logic                     vsync,
    output logic                     hblank,
    output logic                     vblank
);
    import lcd_video_pkg::*;

    // capture to store
    logic      wr_en;
    logic      frame_done;
    fb_addr_t  wr_addr;
    column_t   wr_data;
    contrast_t wr_contrast;

    // scan to store and shading
    fb_addr_t   rd_addr;
    logic [2:0] pixel_row;
    logic       scan_hsync;
    logic       scan_vsync;
    logic       scan_hblank;
    logic       scan_vblank;
    column_t    bank_column [4];
    contrast_t  bank_contrast [4];

    lcd_capture capture0
    (
        .clk_sys        (clk_sys),
        .reset          (reset),
        .frame_complete (frame_complete),
        .column_ce      (column_ce),
        .lcd_column     (lcd_column),
        .lcd_contrast   (lcd_contrast),
        .lcd_read_x     (lcd_read_x),
        .lcd_read_y     (lcd_read_y),
        .wr_en          (wr_en),
        .frame_done     (frame_done),
        .wr_addr        (wr_addr),
        .wr_data        (wr_data),
        .wr_contrast    (wr_contrast)
    );

    frame_store store0
    (
        .clk_sys       (clk_sys),
        .reset         (reset),
        .wr_en         (wr_en),
        .frame_done    (frame_done),
        .pix_ce        (pix_ce),
        .wr_addr       (wr_addr),
        .rd_addr       (rd_addr),
        .wr_data       (wr_data),
        .wr_contrast   (wr_contrast),
        .bank_column   (bank_column),
        .bank_contrast (bank_contrast)
    );

    raster_scan scan0
    (
        .clk_sys   (clk_sys),
        .reset     (reset),
        .pix_ce    (pix_ce),
        .rd_addr   (rd_addr),
        .pixel_row (pixel_row),
        .hsync     (scan_hsync),
        .vsync     (scan_vsync),
        .hblank    (scan_hblank),
        .vblank    (scan_vblank)
    );

    pixel_shade shade0
    (
        .clk_sys       (clk_sys),
        .reset         (reset),
        .pix_ce        (pix_ce),
        .blend_mode    (blend_mode),
        .hsync_in      (scan_hsync),
        .vsync_in      (scan_vsync),
        .hblank_in     (scan_hblank),
        .vblank_in     (scan_vblank),
        .pixel_row     (pixel_row),
        .bank_column   (bank_column),
        .bank_contrast (bank_contrast),
        .red           (red),
        .green         (green),
        .blue          (blue),
        .hsync         (hsync),
        .vsync         (vsync),
        .hblank        (hblank),
        .vblank        (vblank)
    );

endmodule

//--- hw/pixel_shade.sv
// Pixel shading: contrast table lookup, optional four-frame blend and
// mixing between the off and on palette greens, registered to RGB.
// Sync and blank flags are delayed two pix_ce stages to match the colour.

`include "lcd_consts.svh"

module pixel_shade
(
    input  logic                     clk_sys,
    input  logic                     reset,
    input  logic                     pix_ce,
    input  logic                     blend_mode,
    input  logic                     hsync_in,
    input  logic                     vsync_in,
    input  logic                     hblank_in,
    input  logic                     vblank_in,
    input  logic [2:0]               pixel_row,
    input  lcd_video_pkg::column_t   bank_column [4],
    input  lcd_video_pkg::contrast_t bank_contrast [4],
    output lcd_video_pkg::channel_t  red,
    output lcd_video_pkg::channel_t  green,
    output lcd_video_pkg::channel_t  blue,
    output logic                     hsync,
    output logic                     vsync,
    output logic                     hblank,
    output logic                     vblank
);
    import lcd_video_pkg::*;

    // {off level, on level} per contrast setting, indexed {contrast, pixel}
    localparam intensity_t level_map [128] = '{
        8'd0,   8'd4,    8'd0,   8'd4,    8'd0,   8'd4,    8'd0,   8'd4,     // 00
        8'd0,   8'd6,    8'd0,   8'd11,   8'd0,   8'd17,   8'd0,   8'd24,    // 04
        8'd0,   8'd31,   8'd0,   8'd40,   8'd0,   8'd48,   8'd0,   8'd57,    // 08
        8'd0,   8'd67,   8'd0,   8'd77,   8'd0,   8'd88,   8'd0,   8'd99,    // 0C
        8'd0,   8'd110,  8'd0,   8'd122,  8'd0,   8'd133,  8'd0,   8'd146,   // 10
        8'd0,   8'd158,  8'd0,   8'd171,  8'd0,   8'd184,  8'd0,   8'd198,   // 14
        8'd0,   8'd212,  8'd0,   8'd226,  8'd0,   8'd240,  8'd0,   8'd255,   // 18
        8'd2,   8'd255,  8'd5,   8'd255,  8'd10,  8'd255,  8'd15,  8'd255,   // 1C
        8'd21,  8'd255,  8'd27,  8'd255,  8'd34,  8'd255,  8'd41,  8'd255,   // 20
        8'd48,  8'd255,  8'd56,  8'd255,  8'd64,  8'd255,  8'd73,  8'd255,   // 24
        8'd81,  8'd255,  8'd90,  8'd255,  8'd100, 8'd255,  8'd109, 8'd255,   // 28
        8'd119, 8'd255,  8'd129, 8'd255,  8'd139, 8'd255,  8'd149, 8'd255,   // 2C
        8'd160, 8'd255,  8'd171, 8'd255,  8'd182, 8'd255,  8'd193, 8'd255,   // 30
        8'd204, 8'd255,  8'd216, 8'd255,  8'd228, 8'd255,  8'd240, 8'd255,   // 34
        8'd240, 8'd255,  8'd240, 8'd255,  8'd240, 8'd255,  8'd240, 8'd255,   // 38
        8'd240, 8'd255,  8'd240, 8'd255,  8'd240, 8'd255,  8'd240, 8'd255    // 3C
    };

    logic [2:0] row_d;
    logic       hsync_d;
    logic       vsync_d;
    logic       hblank_d;
    logic       vblank_d;
    intensity_t level [4];
    logic [9:0] level_sum;
    intensity_t intensity;

    // ((255 - i) * off + i * on) / 255, fits 16 bits
    function automatic channel_t mix(intensity_t i, channel_t off_c, channel_t on_c);
        logic [15:0] acc;
        acc = {8'h00, 8'hFF - i} * {8'h00, off_c} + {8'h00, i} * {8'h00, on_c};
        return channel_t'(acc / 16'd255);
    endfunction

    always_comb
    begin
        level_sum = '0;
        for (int age = 0; age < 4; age++)
        begin
            level[age] = level_map[{bank_contrast[age], bank_column[age][row_d]}];
            level_sum  = level_sum + 10'(level[age]);
        end
        intensity = blend_mode ? level_sum[9:2] : level[0];   // blend gives grey shades
    end

    always_ff @(posedge clk_sys)
    begin
        if (pix_ce)
            row_d <= pixel_row;     // same stage as the bank bytes
    end

    always_ff @(posedge clk_sys)
    begin
        if (reset)
        begin
            {hsync_d, vsync_d, hblank_d, vblank_d} <= 4'b0011;
            {hsync, vsync, hblank, vblank}         <= 4'b0011;
            red   <= '0;
            green <= '0;
            blue  <= '0;
        end
        else if (pix_ce)
        begin
            {hsync_d, vsync_d, hblank_d, vblank_d} <= {hsync_in, vsync_in, hblank_in, vblank_in};
            {hsync, vsync, hblank, vblank}         <= {hsync_d, vsync_d, hblank_d, vblank_d};
            if (hblank_d || vblank_d)
            begin
                red   <= '0;
                green <= '0;
                blue  <= '0;
            end
            else
            begin
                red   <= mix(intensity, `OFF_R, `ON_R);
                green <= mix(intensity, `OFF_G, `ON_G);
                blue  <= mix(intensity, `OFF_B, `ON_B);
            end
        end
    end

endmodule

//--- hw/raster_scan.sv
// Fixed 407 x 262 raster with the 96 x 64 image centred in it.
// All outputs describe the same raster position and move on each pix_ce;
// rd_addr and pixel_row select the image pixel at that position.

`include "lcd_consts.svh"

module raster_scan
(
    input  logic                    clk_sys,
    input  logic                    reset,
    input  logic                    pix_ce,
    output lcd_video_pkg::fb_addr_t rd_addr,
    output logic [2:0]              pixel_row,
    output logic                    hsync,
    output logic                    vsync,
    output logic                    hblank,
    output logic                    vblank
);
    import lcd_video_pkg::*;

    localparam raster_t H_LAST    = raster_t'(`H_TOTAL - 1);
    localparam raster_t V_LAST    = raster_t'(`V_TOTAL - 1);
    localparam raster_t H_ACT_END = raster_t'(`H_START + `LCD_XSIZE);
    localparam raster_t V_ACT_END = raster_t'(`V_START + `LCD_YSIZE);
    localparam raster_t X_LAST    = raster_t'(`LCD_XSIZE - 1);

    raster_t h_count;
    raster_t v_count;
    raster_t next_h;
    raster_t next_v;
    raster_t img_x;
    raster_t img_y;

    always_comb
    begin
        next_h = h_count + 1'b1;
        next_v = v_count;
        if (h_count == H_LAST)
        begin
            next_h = '0;
            next_v = (v_count == V_LAST) ? '0 : v_count + 1'b1;
        end
    end

    // flags are decoded from the next position so they line up with the counters
    always_ff @(posedge clk_sys)
    begin
        if (reset)
        begin
            h_count <= '0;
            v_count <= '0;
            hsync   <= 1'b0;
            vsync   <= 1'b0;
            hblank  <= 1'b1;
            vblank  <= 1'b1;
            img_x   <= '0;
            img_y   <= '0;
        end
        else if (pix_ce)
        begin
            h_count <= next_h;
            v_count <= next_v;
            hblank  <= !(next_h >= raster_t'(`H_START) && next_h < H_ACT_END);
            vblank  <= !(next_v >= raster_t'(`V_START) && next_v < V_ACT_END);
            hsync   <= (next_h >= raster_t'(`HS_START) && next_h <= raster_t'(`HS_END));
            if (next_h == raster_t'(`HS_START))
            begin
                if (next_v == raster_t'(`VS_LINE_ON))
                    vsync <= 1'b1;
                if (next_v == raster_t'(`VS_LINE_OFF))
                    vsync <= 1'b0;
            end

            // image position, only moves inside the active window
            if (vblank)
            begin
                img_x <= '0;
                img_y <= '0;
            end
            else if (!hblank)
            begin
                img_x <= (img_x == X_LAST) ? '0 : img_x + 1'b1;
                if (img_x == X_LAST)
                    img_y <= img_y + 1'b1;
            end
        end
    end

    assign rd_addr   = fb_addr_t'(img_y[5:3]) * fb_addr_t'(`LCD_XSIZE) + fb_addr_t'(img_x);
    assign pixel_row = img_y[2:0];   // bit within the column byte

endmodule

//--- hw/frame_store.sv
// Four rotating frame banks with one contrast latch per bank.
// Capture fills the write bank; on frame_done that bank becomes the read
// bank. Reads return all four banks, newest first, one pix_ce later.

`include "lcd_consts.svh"

module frame_store
(
    input  logic                     clk_sys,
    input  logic                     reset,
    input  logic                     wr_en,
    input  logic                     frame_done,
    input  logic                     pix_ce,
    input  lcd_video_pkg::fb_addr_t  wr_addr,
    input  lcd_video_pkg::fb_addr_t  rd_addr,
    input  lcd_video_pkg::column_t   wr_data,
    input  lcd_video_pkg::contrast_t wr_contrast,
    output lcd_video_pkg::column_t   bank_column [4],
    output lcd_video_pkg::contrast_t bank_contrast [4]
);
    import lcd_video_pkg::*;

    column_t   fb [4][`FB_DEPTH];
    contrast_t contrast_latch [4];
    bank_t     wr_bank;
    bank_t     rd_bank;

    ////////////////////////////////////////////////////////////////////
    // bank rotation

    always_ff @(posedge clk_sys)
    begin
        if (reset)
        begin
            wr_bank <= bank_t'(1);
            rd_bank <= bank_t'(0);
        end
        else if (frame_done)
        begin
            rd_bank <= wr_bank;             // show the frame just finished
            wr_bank <= wr_bank + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // write and read ports

    always_ff @(posedge clk_sys)
    begin
        if (wr_en)
        begin
            fb[wr_bank][wr_addr]    <= wr_data;
            contrast_latch[wr_bank] <= wr_contrast;
        end
    end

    // entry 0 is the read bank, then older frames, wrapping mod 4
    always_ff @(posedge clk_sys)
    begin
        if (pix_ce)
        begin
            for (int age = 0; age < 4; age++)
            begin
                bank_column[age]   <= fb[rd_bank - bank_t'(age)][rd_addr];
                bank_contrast[age] <= contrast_latch[rd_bank - bank_t'(age)];
            end
        end
    end

endmodule

//--- hw/lcd_capture.sv
// Frame capture from the LCD controller.
// Armed by frame_complete, it reads one column byte per column_ce, walking
// x then the byte row, and writes each byte with the contrast to the store.

`include "lcd_consts.svh"

module lcd_capture
(
    input  logic                     clk_sys,
    input  logic                     reset,
    input  logic                     frame_complete,
    input  logic                     column_ce,
    input  lcd_video_pkg::column_t   lcd_column,
    input  lcd_video_pkg::contrast_t lcd_contrast,
    output lcd_video_pkg::lcd_x_t    lcd_read_x,
    output lcd_video_pkg::lcd_row_t  lcd_read_y,
    output logic                     wr_en,
    output logic                     frame_done,
    output lcd_video_pkg::fb_addr_t  wr_addr,
    output lcd_video_pkg::column_t   wr_data,
    output lcd_video_pkg::contrast_t wr_contrast
);
    import lcd_video_pkg::*;

    capture_state_t state;
    logic           last_x;
    logic           last_col;

    assign last_x   = (lcd_read_x == lcd_x_t'(`LCD_XSIZE - 1));
    assign last_col = last_x && (lcd_read_y == lcd_row_t'(`LCD_COLS - 1));

    always_ff @(posedge clk_sys)
    begin
        if (reset)
        begin
            state      <= CAP_IDLE;
            lcd_read_x <= '0;
            lcd_read_y <= '0;
            wr_en      <= 1'b0;
            frame_done <= 1'b0;
        end
        else
        begin
            wr_en      <= 1'b0;
            frame_done <= 1'b0;
            case (state)
                CAP_IDLE:
                begin
                    if (frame_complete)
                        state <= CAP_READING;
                end
                CAP_READING:
                begin
                    if (column_ce)
                    begin
                        wr_en      <= 1'b1;
                        frame_done <= last_col;     // with the final write
                        lcd_read_x <= last_x ? '0 : lcd_read_x + 1'b1;
                        if (last_x)
                            lcd_read_y <= last_col ? '0 : lcd_read_y + 1'b1;
                        if (last_col)
                            state <= CAP_IDLE;      // late frame_complete is dropped
                    end
                end
                default: state <= CAP_IDLE;
            endcase
        end
    end

    // write payload, sampled at the same strobe as the address
    always_ff @(posedge clk_sys)
    begin
        if (column_ce)
        begin
            wr_addr     <= fb_addr_t'(lcd_read_y) * fb_addr_t'(`LCD_XSIZE)
                         + fb_addr_t'(lcd_read_x);
            wr_data     <= lcd_column;
            wr_contrast <= lcd_contrast;
        end
    end

endmodule

//--- hw/lcd_video_pkg.sv
// Shared types of the LCD video path.
// Modules import it inside their body and use scoped names in their ports.

package lcd_video_pkg;

    // one lcd column byte, bit n is pixel row n of the byte
    typedef logic [7:0] column_t;

    typedef logic [5:0] contrast_t;     // lcd contrast register

    typedef logic [7:0] lcd_x_t;        // lcd column index
    typedef logic [3:0] lcd_row_t;      // row of column bytes

    // frame bank address, row * 96 + column
    typedef logic [9:0] fb_addr_t;

    typedef logic [1:0] bank_t;         // one of four frame banks

    typedef logic [8:0] raster_t;       // raster or image coordinate

    typedef logic [7:0] intensity_t;    // shade level, 0 off .. 255 on
    typedef logic [7:0] channel_t;      // one colour channel

    typedef enum logic
    {
        CAP_IDLE,
        CAP_READING
    } capture_state_t;

endpackage

//--- include/lcd_consts.svh
// Sizes, raster timing and palette of the handheld LCD video path.
// Include wherever a module needs a dimension, a sync position or a colour.

`ifndef LCD_CONSTS_SVH
`define LCD_CONSTS_SVH

`define LCD_XSIZE   96      // lcd pixels per line
`define LCD_YSIZE   64      // lcd pixel lines
`define LCD_COLS    8       // rows of 8-pixel column bytes
`define FB_DEPTH    768     // bytes per frame bank

`define H_TOTAL     407     // pixels per raster line
`define V_TOTAL     262     // lines per raster frame
`define H_START     155     // first active pixel, centred
`define V_START     99      // first active line, centred
`define HS_START    383
`define HS_END      406
`define VS_LINE_ON  1       // vsync rises on this line's hsync
`define VS_LINE_OFF 4

// palette, pixel off is pale green, pixel on is dark green
`define OFF_R       8'hB7
`define OFF_G       8'hCA
`define OFF_B       8'hB7
`define ON_R        8'h04
`define ON_G        8'h16
`define ON_B        8'h04

`endif
